// ==== sim.f ====
+incdir+source
source/cache_pkg.sv
source/mem_pkg.sv
source/dpsram.sv
source/icache_ctrl.sv
source/icache.sv
tb/tb_clkgen.sv
tb/icache_props.sv
tb/icache_tb.sv

// ==== tb/icache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_tb;
  import cache_pkg::*;
  import mem_pkg::*;

  localparam int unsigned SETS           = 64;
  localparam int unsigned LINE_BYTES     = LINE_WORDS * 4;
  localparam logic [31:0] MEM_XOR        = 32'h5a5a_0000;      // Memory content rule
  localparam logic [31:0] SEED           = 32'hbbab;
  localparam int unsigned RAND_REQS      = 300;
  localparam int unsigned HIT_WAIT       = 2;                   // Accept edge plus lookup
  localparam int unsigned RESP_LIMIT     = 64;                  // Per request bound
  localparam int unsigned TIMEOUT_CYCLES = 20000;               // Three times 300 misses of ~22 cycles

  logic        clk0;
  logic        rst_n0;
  cpu_req_t    req_i;
  logic        inval_i;
  mem_resp_t   mem_resp_i;
  cpu_resp_t   resp_o;
  logic        busy_o;
  mem_req_t    mem_req_o;

  int unsigned err_cnt    = 0;
  int unsigned check_cnt  = 0;
  int unsigned cycle_cnt  = 0;
  int unsigned refill_cnt = 0;                                 // mem_req_o pulses seen
  logic [31:0] last_fill_addr;
  logic [31:0] addr_seed;
  logic [31:0] mem_seed;
  logic        shadow_valid [SETS];                            // Reference tag store
  logic [31:0] shadow_tag   [SETS];

  tb_clkgen #(.PERIOD_NS(20), .RST_CYCLES(8)) u_clkgen (.clk0(clk0), .rst_n0(rst_n0));

  icache #(.SETS(SETS)) u_icache (
    .clk0       (clk0),
    .rst_n0     (rst_n0),
    .req_i      (req_i),
    .inval_i    (inval_i),
    .mem_resp_i (mem_resp_i),
    .resp_o     (resp_o),
    .busy_o     (busy_o),
    .mem_req_o  (mem_req_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ MEM_XOR;                      // Word's own byte address
  endfunction

  function automatic int unsigned set_of(input logic [31:0] addr);
    return (addr / LINE_BYTES) % SETS;
  endfunction

  function automatic logic [31:0] tag_of(input logic [31:0] addr);
    return addr / (LINE_BYTES * SETS);
  endfunction

  // Memory side model answering each refill request with four beats
  initial begin : mem_responder
    logic [31:0] line_addr;
    mem_resp_i = '0;
    mem_seed   = SEED;
    forever begin
      @(negedge clk0);
      if (rst_n0 && mem_req_o.valid === 1'b1) begin
        line_addr = mem_req_o.addr;
        mem_seed  = lcg_next(mem_seed);
        repeat (mem_seed[17:16]) @(negedge clk0);             // 0 to 3 cycles
        for (int b = 0; b < LINE_WORDS; b++) begin
          mem_resp_i.valid = 1'b1;
          mem_resp_i.data  = mem_word(line_addr + 4 * b);
          @(negedge clk0);
          mem_resp_i = '0;
          mem_seed   = lcg_next(mem_seed);
          repeat (mem_seed[31:16] % 3) @(negedge clk0);       // Idle gap
        end
      end
    end
  end

  always @(negedge clk0) begin
    if (mem_req_o.valid === 1'b1) begin
      refill_cnt++;
      last_fill_addr = mem_req_o.addr;
    end
  end

  task automatic finish_run();
    int unsigned assert_fails;
    assert_fails = u_icache.u_props.assert_fail_cnt;
    $display("Checks: %0d  check errors: %0d  assertion failures: %0d",
             check_cnt, err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // One request checked against the memory rule and the shadow tags
  task automatic read_check(input string test, input logic [31:0] addr,
                            output logic predicted, output logic missed);
    int unsigned set_idx;
    int unsigned waited;
    int unsigned fills_before;
    int unsigned fills;
    set_idx   = set_of(addr);
    predicted = !shadow_valid[set_idx] || (shadow_tag[set_idx] != tag_of(addr));
    while (busy_o) begin
      @(negedge clk0);
    end
    fills_before = refill_cnt;
    req_i.valid  = 1'b1;
    req_i.addr   = addr;
    @(negedge clk0);
    req_i  = '0;
    waited = 1;
    while (resp_o.valid !== 1'b1 && waited < RESP_LIMIT) begin
      @(negedge clk0);
      waited++;
    end
    fills  = refill_cnt - fills_before;
    missed = (fills != 0);
    check_cnt++;
    if (resp_o.valid !== 1'b1) begin
      err_cnt++;
      $display("%s: no response for address %h within %0d cycles", test, addr, RESP_LIMIT);
    end else if (resp_o.data !== mem_word(addr)) begin
      err_cnt++;
      $display("[ERROR] %s data @%h: expected %h, actual %h",
               test, addr, mem_word(addr), resp_o.data);
    end
    check_cnt++;
    if (fills != predicted) begin
      err_cnt++;
      $display("[ERROR] %s refills @%h: expected %0d, actual %0d", test, addr, predicted, fills);
    end
    check_cnt++;
    if (missed && last_fill_addr !== (addr & ~(LINE_BYTES - 1))) begin
      err_cnt++;
      $display("[ERROR] %s fill address: expected %h, actual %h",
               test, addr & ~(LINE_BYTES - 1), last_fill_addr);
    end else if (!missed && waited != HIT_WAIT) begin
      err_cnt++;
      $display("[ERROR] %s hit latency @%h: expected %0d, actual %0d",
               test, addr, HIT_WAIT, waited);
    end
    shadow_valid[set_idx] = 1'b1;
    shadow_tag[set_idx]   = tag_of(addr);
  endtask

  task automatic cold_miss();
    logic predicted;
    logic missed;
    read_check("cold_miss", 32'h0000_1238, predicted, missed);
    check_cnt++;
    if (!missed) begin
      err_cnt++;
      $display("cold_miss: first access to a line caused no refill");
    end
  endtask

  task automatic same_line_hits();
    logic        predicted;
    logic        missed;
    logic [31:0] words [3];
    words = '{32'h0000_1230, 32'h0000_1234, 32'h0000_123c};   // Rest of the cold line
    foreach (words[i]) begin
      read_check("same_line_hits", words[i], predicted, missed);
      check_cnt++;
      if (missed) begin
        err_cnt++;
        $display("same_line_hits: refill for %h on a line already loaded", words[i]);
      end
    end
  endtask

  task automatic set_conflict();
    logic predicted;
    logic missed;
    read_check("set_conflict", 32'h0000_1238 + SETS * LINE_BYTES, predicted, missed);
    check_cnt++;
    if (!missed) begin
      err_cnt++;
      $display("set_conflict: new tag in a used set did not refill");
    end
    read_check("set_conflict", 32'h0000_1238, predicted, missed); // Evicted line back
    check_cnt++;
    if (!missed) begin
      err_cnt++;
      $display("set_conflict: evicted line hit");
    end
  endtask

  task automatic flush_all();
    logic        predicted;
    logic        missed;
    int unsigned busy_cycles;
    logic        stray_resp;
    logic [31:0] filled [$];
    read_check("flush_all", 32'h0000_2000, predicted, missed);
    read_check("flush_all", 32'h0000_2014, predicted, missed);
    read_check("flush_all", 32'h0000_23f0, predicted, missed);  // Last set
    for (int s = 0; s < SETS; s++) begin
      if (shadow_valid[s]) begin
        filled.push_back((shadow_tag[s] * SETS + s) * LINE_BYTES);
      end
      shadow_valid[s] = 1'b0;
    end
    req_i.valid = 1'b1;                                        // Loses to the invalidate
    req_i.addr  = 32'h0000_2000;
    inval_i     = 1'b1;
    @(negedge clk0);
    req_i       = '0;
    inval_i     = 1'b0;
    busy_cycles = 0;
    stray_resp  = 1'b0;
    while (busy_o && busy_cycles <= SETS + 4) begin
      busy_cycles++;
      stray_resp |= resp_o.valid;
      @(negedge clk0);
    end
    stray_resp |= resp_o.valid;                                // Cycle the walk ends
    check_cnt++;
    if (busy_cycles != SETS) begin
      err_cnt++;
      $display("[ERROR] flush_all busy cycles: expected %0d, actual %0d", SETS, busy_cycles);
    end
    check_cnt++;
    if (stray_resp) begin
      err_cnt++;
      $display("flush_all: request beside the invalidate got a response");
    end
    foreach (filled[i]) begin
      read_check("flush_all", filled[i], predicted, missed);
      check_cnt++;
      if (!missed) begin
        err_cnt++;
        $display("flush_all: line %h hit after invalidation", filled[i]);
      end
    end
  endtask

  task automatic random_reads();
    logic [31:0] addr;
    logic        predicted;
    logic        missed;
    int unsigned exp_fills;
    int unsigned fills_start;
    exp_fills   = 0;
    fills_start = refill_cnt;
    for (int n = 0; n < RAND_REQS; n++) begin
      addr_seed = lcg_next(addr_seed);
      addr      = {21'd0, addr_seed[26:18], 2'b00};            // 2 KB range gives two tags per set
      read_check("random_reads", addr, predicted, missed);
      exp_fills += predicted;
      repeat (addr_seed[31:30] % 3) @(negedge clk0);
    end
    check_cnt++;
    if (refill_cnt - fills_start != exp_fills) begin
      err_cnt++;
      $display("[ERROR] random_reads refill count: expected %0d, actual %0d",
               exp_fills, refill_cnt - fills_start);
    end
  endtask

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk0);
      cycle_cnt++;
    end
    err_cnt++;
    $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
    finish_run();
  end

  initial begin : main
    req_i     = '0;
    inval_i   = 1'b0;
    addr_seed = SEED;
    for (int s = 0; s < SETS; s++) begin
      shadow_valid[s] = 1'b0;
      shadow_tag[s]   = '0;
    end
    @(posedge rst_n0);
    @(negedge clk0);
    check_cnt++;
    if (busy_o !== 1'b0 || resp_o.valid !== 1'b0 || mem_req_o.valid !== 1'b0) begin
      err_cnt++;
      $display("Outputs not idle after reset");
    end
    cold_miss();
    same_line_hits();
    set_conflict();
    flush_all();
    random_reads();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== tb/icache_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_props (
  input wire                       clk0,
  input wire                       rst_n0,
  input wire cache_pkg::cpu_req_t  req_i,
  input wire                       inval_i,
  input wire mem_pkg::mem_resp_t   mem_resp_i,
  input wire cache_pkg::cpu_resp_t resp_o,
  input wire                       busy_o,
  input wire mem_pkg::mem_req_t    mem_req_o
);
  import cache_pkg::*;

  int unsigned assert_fail_cnt = 0;                            // Summed into the final tally
  logic        pending_q;                                      // Request waiting for its response
  logic        fill_open_q;                                    // Refill beats still owed
  logic [2:0]  beat_cnt_q;
  logic        req_accept;

  assign req_accept = req_i.valid && !inval_i && !busy_o;      // Invalidate wins

  always_ff @(posedge clk0) begin
    if (!rst_n0) begin
      pending_q   <= 1'b0;
      fill_open_q <= 1'b0;
      beat_cnt_q  <= '0;
    end else begin
      if (req_accept) begin
        pending_q <= 1'b1;
      end else if (resp_o.valid) begin
        pending_q <= 1'b0;
      end
      if (mem_req_o.valid) begin
        fill_open_q <= 1'b1;
        beat_cnt_q  <= {2'b00, mem_resp_i.valid};              // First beat may coincide
      end else if (mem_resp_i.valid) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if (beat_cnt_q == 3'(LINE_WORDS - 1)) begin
          fill_open_q <= 1'b0;                                 // Line complete
          beat_cnt_q  <= '0;
        end
      end
    end
  end

  resp_after_req: assert property (@(posedge clk0) disable iff (!rst_n0)
    resp_o.valid |-> pending_q)
    else begin
      assert_fail_cnt++;
      $error("response pulse with no accepted request");
    end

  one_fill_at_a_time: assert property (@(posedge clk0) disable iff (!rst_n0)
    mem_req_o.valid |-> !fill_open_q)
    else begin
      assert_fail_cnt++;
      $error("second refill request before four beats");
    end

  busy_after_inval: assert property (@(posedge clk0) disable iff (!rst_n0)
    (inval_i && !busy_o) |=> busy_o)
    else begin
      assert_fail_cnt++;
      $error("busy low after an accepted invalidate");
    end

  idle_after_reset: assert property (@(posedge clk0)
    $rose(rst_n0) |-> (!resp_o.valid && !mem_req_o.valid && !busy_o))
    else begin
      assert_fail_cnt++;
      $error("outputs active right after reset");
    end

endmodule

bind icache icache_props u_props (.*);

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
  parameter int unsigned PERIOD_NS  = 20,
  parameter int unsigned RST_CYCLES = 8                       // Rising edges held in reset
) (
  output logic clk0,
  output logic rst_n0
);

  initial begin
    clk0 = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk0 = ~clk0;
    end
  end

  // Release on a falling edge, like every other stimulus
  initial begin
    rst_n0 = 1'b0;
    repeat (RST_CYCLES) @(posedge clk0);
    @(negedge clk0);
    rst_n0 = 1'b1;
  end

endmodule

`default_nettype wire

// ==== source/icache.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache #(
  parameter int unsigned SETS = 64                                  // Power of two, at least 2
) (
  input  wire                     clk0,
  input  wire                     rst_n0,
  input  wire  cache_pkg::cpu_req_t req_i,
  input  wire                     inval_i,
  input  wire  mem_pkg::mem_resp_t  mem_resp_i,
  output cache_pkg::cpu_resp_t      resp_o,
  output logic                    busy_o,
  output mem_pkg::mem_req_t         mem_req_o
);
  import cache_pkg::*;

  localparam int unsigned SET_W  = $clog2(SETS);
  localparam int unsigned TAG_W  = ADDR_W - SET_W - $clog2(LINE_WORDS) - 2;
  localparam int unsigned LINE_W = LINE_WORDS * WORD_W;

  logic [SET_W-1:0]      tag_raddr;
  logic                  tag_ren;
  logic [SET_W-1:0]      tag_waddr;
  logic                  tag_wen;
  logic [TAG_W:0]        tag_wdata;                                 // {valid, tag}
  logic [TAG_W:0]        tag_rdata;
  logic [SET_W-1:0]      data_raddr;
  logic                  data_ren;
  logic [SET_W-1:0]      data_waddr;
  logic [LINE_WORDS-1:0] data_we;
  logic [LINE_W-1:0]     data_wdata;
  logic [LINE_W-1:0]     data_rdata;

  icache_ctrl #(
    .SETS  (SETS),
    .TAG_W (TAG_W)
  ) u_ctrl (
    .clk0         (clk0),
    .rst_n0       (rst_n0),
    .req_i        (req_i),
    .inval_i      (inval_i),
    .mem_resp_i   (mem_resp_i),
    .tag_rdata_i  (tag_rdata),
    .data_rdata_i (data_rdata),
    .resp_o       (resp_o),
    .busy_o       (busy_o),
    .mem_req_o    (mem_req_o),
    .tag_raddr_o  (tag_raddr),
    .tag_ren_o    (tag_ren),
    .tag_waddr_o  (tag_waddr),
    .tag_wen_o    (tag_wen),
    .tag_wdata_o  (tag_wdata),
    .data_raddr_o (data_raddr),
    .data_ren_o   (data_ren),
    .data_waddr_o (data_waddr),
    .data_we_o    (data_we),
    .data_wdata_o (data_wdata)
  );

  // Tag RAM, a single lane holding valid and tag
  dpsram #(
    .DATA_WIDTH (TAG_W + 1),
    .DATA_DEPTH (SETS),
    .BYTE_SIZE  (TAG_W + 1)
  ) u_tag_ram (
    .clk0     (clk0),
    .rst_n0   (rst_n0),
    .addr0_i  (tag_raddr),
    .en0_i    (tag_ren),
    .we0_i    (1'b0),                                              // Lookup port reads only
    .wdata0_i ('0),
    .rdata0_o (tag_rdata),
    .clk1     (clk0),
    .rst_n1   (rst_n0),
    .addr1_i  (tag_waddr),
    .en1_i    (tag_wen),
    .we1_i    (tag_wen),
    .wdata1_i (tag_wdata),
    .rdata1_o ()
  );

  // Data RAM, one lane per word of the line
  dpsram #(
    .DATA_WIDTH (LINE_W),
    .DATA_DEPTH (SETS),
    .BYTE_SIZE  (WORD_W)
  ) u_data_ram (
    .clk0     (clk0),
    .rst_n0   (rst_n0),
    .addr0_i  (data_raddr),
    .en0_i    (data_ren),
    .we0_i    ('0),
    .wdata0_i ('0),
    .rdata0_o (data_rdata),
    .clk1     (clk0),
    .rst_n1   (rst_n0),
    .addr1_i  (data_waddr),
    .en1_i    (|data_we),                                          // Any refill lane
    .we1_i    (data_we),
    .wdata1_i (data_wdata),
    .rdata1_o ()
  );

endmodule

`default_nettype wire

// ==== source/icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl #(
  parameter int unsigned SETS  = 64,                                // Power of two
  parameter int unsigned TAG_W = 22                                 // Derived by top
) (
  input  wire                                                clk0,
  input  wire                                                rst_n0,
  input  wire  cache_pkg::cpu_req_t                           req_i,
  input  wire                                                inval_i,
  input  wire  mem_pkg::mem_resp_t                            mem_resp_i,
  input  wire  [TAG_W:0]                                      tag_rdata_i,  // {valid, tag}
  input  wire  [cache_pkg::LINE_WORDS*cache_pkg::WORD_W-1:0]  data_rdata_i, // Whole line
  output cache_pkg::cpu_resp_t                                resp_o,
  output logic                                               busy_o,
  output mem_pkg::mem_req_t                                   mem_req_o,
  output logic [$clog2(SETS)-1:0]                             tag_raddr_o,
  output logic                                               tag_ren_o,
  output logic [$clog2(SETS)-1:0]                             tag_waddr_o,
  output logic                                               tag_wen_o,
  output logic [TAG_W:0]                                      tag_wdata_o,
  output logic [$clog2(SETS)-1:0]                             data_raddr_o,
  output logic                                               data_ren_o,
  output logic [$clog2(SETS)-1:0]                             data_waddr_o,
  output logic [cache_pkg::LINE_WORDS-1:0]                    data_we_o,    // One lane per beat
  output logic [cache_pkg::LINE_WORDS*cache_pkg::WORD_W-1:0]  data_wdata_o
);
  import cache_pkg::*;
  import mem_pkg::*;

  localparam int unsigned SET_W  = $clog2(SETS);
  localparam int unsigned WSEL_W = $clog2(LINE_WORDS);             // Word within line
  localparam int unsigned OFF_W  = WSEL_W + 2;                     // Plus byte offset
  localparam int unsigned TAG_LO = OFF_W + SET_W;

  if (SETS < 2 || (1 << SET_W) != SETS) begin : g_bad_sets
    $error("icache_ctrl needs SETS as a power of two of at least 2");
  end
  if (TAG_LO + TAG_W != ADDR_W) begin : g_bad_tag
    $error("icache_ctrl TAG_W does not fill the address");
  end

  cache_state_e                      state_q;
  cache_state_e                      state_d;
  logic [ADDR_W-1:0]                 addr_q;                        // Latched request
  logic [SET_W-1:0]                  flush_q;                       // Walk pointer
  logic [WSEL_W-1:0]                 beat_q;                        // Next lane to fill
  cpu_resp_t                         resp_q;
  mem_req_t                          mem_req_q;
  logic                              accept_req;
  logic                              accept_inval;
  logic                              hit;
  logic                              last_beat;
  logic [SET_W-1:0]                  req_idx;
  logic [SET_W-1:0]                  cur_idx;
  logic [TAG_W-1:0]                  cur_tag;
  logic [WSEL_W-1:0]                 cur_word;
  logic [LINE_WORDS-1:0][WORD_W-1:0] line_words;
  logic [LINE_WORDS-1:0]             lane_sel;

  // Invalidate wins over a request in the same cycle
  assign accept_inval = inval_i && (state_q == IDLE);
  assign accept_req   = req_i.valid && !inval_i && (state_q == IDLE);

  assign req_idx    = req_i.addr[OFF_W +: SET_W];
  assign cur_idx    = addr_q[OFF_W +: SET_W];
  assign cur_tag    = addr_q[TAG_LO +: TAG_W];
  assign cur_word   = addr_q[2 +: WSEL_W];
  assign line_words = data_rdata_i;

  assign hit       = tag_rdata_i[TAG_W] && (tag_rdata_i[TAG_W-1:0] == cur_tag);
  assign last_beat = mem_resp_i.valid && (beat_q == WSEL_W'(LINE_WORDS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept_inval) begin
          state_d = FLUSH;
        end else if (accept_req) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        state_d = hit ? IDLE : REFILL;                              // Miss starts refill
      end
      REFILL: begin
        if (last_beat) begin
          state_d = REPLAY;
        end
      end
      REPLAY: begin
        state_d = LOOKUP;                                           // Read issued here
      end
      FLUSH: begin
        if (flush_q == SET_W'(SETS - 1)) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Port 0 reads, new request in IDLE or replay of the latched one
  always_comb begin
    tag_ren_o   = accept_req;
    tag_raddr_o = req_idx;
    if (state_q == REPLAY) begin
      tag_ren_o   = 1'b1;
      tag_raddr_o = cur_idx;
    end
  end

  assign data_ren_o   = tag_ren_o;                                  // Tag and line together
  assign data_raddr_o = tag_raddr_o;

  // Port 1 tag writes, valid on last beat and cleared during walk
  always_comb begin
    tag_wen_o   = (state_q == REFILL) && last_beat;
    tag_waddr_o = cur_idx;
    tag_wdata_o = {1'b1, cur_tag};
    if (state_q == FLUSH) begin
      tag_wen_o   = 1'b1;
      tag_waddr_o = flush_q;
      tag_wdata_o = '0;
    end
  end

  always_comb begin
    lane_sel         = '0;
    lane_sel[beat_q] = 1'b1;
  end

  assign data_waddr_o = cur_idx;
  assign data_we_o    = ((state_q == REFILL) && mem_resp_i.valid) ? lane_sel : '0;
  assign data_wdata_o = {LINE_WORDS{mem_resp_i.data}};             // Lane enable picks one

  always_ff @(posedge clk0) begin
    if (!rst_n0) begin
      state_q         <= IDLE;
      flush_q         <= '0;
      beat_q          <= '0;
      resp_q.valid    <= 1'b0;
      mem_req_q.valid <= 1'b0;
    end else begin
      state_q         <= state_d;
      resp_q.valid    <= (state_q == LOOKUP) && hit;
      mem_req_q.valid <= (state_q == LOOKUP) && !hit;              // Pulse after lookup
      if (state_q == FLUSH) begin
        flush_q <= flush_q + 1'b1;                                  // Wraps to 0 at end
      end
      if ((state_q == REFILL) && mem_resp_i.valid) begin
        beat_q <= beat_q + 1'b1;                                    // Wraps after last beat
      end
    end
    // Payload, no reset
    if (accept_req) begin
      addr_q <= req_i.addr;
    end
    if (state_q == LOOKUP) begin
      resp_q.data    <= line_words[cur_word];
      mem_req_q.addr <= {addr_q[ADDR_W-1:OFF_W], OFF_W'(0)};       // Line aligned
    end
  end

  assign resp_o    = resp_q;
  assign mem_req_o = mem_req_q;
  assign busy_o    = (state_q != IDLE);

endmodule

`default_nettype wire

// ==== source/dpsram.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "a_defines.svh"

module dpsram #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned DATA_DEPTH = 1024,
  parameter int unsigned BYTE_SIZE  = 32                          // Lane width
) (
  input  wire                                   clk0,
  input  wire                                   rst_n0,
  input  wire  [$clog2(DATA_DEPTH)-1:0]         addr0_i,
  input  wire                                   en0_i,
  input  wire  [(DATA_WIDTH/BYTE_SIZE)-1:0]     we0_i,
  input  wire  [DATA_WIDTH-1:0]                 wdata0_i,
  output logic [DATA_WIDTH-1:0]                 rdata0_o,

  input  wire                                   clk1,
  input  wire                                   rst_n1,
  input  wire  [$clog2(DATA_DEPTH)-1:0]         addr1_i,
  input  wire                                   en1_i,
  input  wire  [(DATA_WIDTH/BYTE_SIZE)-1:0]     we1_i,
  input  wire  [DATA_WIDTH-1:0]                 wdata1_i,
  output logic [DATA_WIDTH-1:0]                 rdata1_o
);

  localparam int unsigned LANES     = DATA_WIDTH / BYTE_SIZE;
  localparam bit          SIM_MODEL = `_VERILATOR;
  localparam bit          RST_CLEAR = `RAM_RST_CLEAR;

  if (SIM_MODEL) begin : g_sim
    logic [LANES-1:0][BYTE_SIZE-1:0] mem_q [DATA_DEPTH];         // Lane split storage
    logic [LANES-1:0][BYTE_SIZE-1:0] rdata0_q;
    logic [LANES-1:0][BYTE_SIZE-1:0] rdata1_q;
    logic [LANES-1:0][BYTE_SIZE-1:0] wdata0_split;
    logic [LANES-1:0][BYTE_SIZE-1:0] wdata1_split;

    assign wdata0_split = wdata0_i;
    assign wdata1_split = wdata1_i;
    assign rdata0_o     = rdata0_q;
    assign rdata1_o     = rdata1_q;

    // Read port, write lanes only forwarded and never stored
    always_ff @(posedge clk0) begin
      if (!rst_n0) begin
        rdata0_q <= '0;
      end else if (en0_i) begin
        for (int unsigned i = 0; i < LANES; i++) begin
          if (we0_i[i]) begin
            rdata0_q[i] <= wdata0_split[i];                     // Write-first echo
          end else begin
            rdata0_q[i] <= mem_q[addr0_i][i];
          end
        end
      end
    end

    // Sole write port, owns the array
    always_ff @(posedge clk1) begin
      if (!rst_n1) begin
        rdata1_q <= '0;
        if (RST_CLEAR) begin
          for (int unsigned a = 0; a < DATA_DEPTH; a++) begin
            mem_q[a] <= '0;                                      // All entries invalid
          end
        end
      end else if (en1_i) begin
        for (int unsigned i = 0; i < LANES; i++) begin
          if (we1_i[i]) begin
            rdata1_q[i]       <= wdata1_split[i];               // Write-first
            mem_q[addr1_i][i] <= wdata1_split[i];
          end else begin
            rdata1_q[i]       <= mem_q[addr1_i][i];
          end
        end
      end
    end
  end else begin : g_no_model
    $error("dpsram has no memory body without the behavioral model");
  end

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // Line fill request toward the memory side
  typedef struct packed {
    logic                        valid;     // One-cycle pulse
    logic [cache_pkg::ADDR_W-1:0] addr;     // Line aligned byte address
  } mem_req_t;

  // One refill beat, words arrive in order
  typedef struct packed {
    logic                        valid;     // Beat strobe
    logic [cache_pkg::WORD_W-1:0] data;     // One word of the line
  } mem_resp_t;

endpackage

`default_nettype wire

// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  parameter int unsigned ADDR_W     = 32;   // Byte address width
  parameter int unsigned WORD_W     = 32;   // CPU word
  parameter int unsigned LINE_WORDS = 4;    // Words per line, one data RAM lane each

  typedef enum logic [2:0] {
    IDLE,                                   // Waiting for request or invalidate
    LOOKUP,                                 // Tag and line read data valid
    REFILL,                                 // Collecting beats from memory
    REPLAY,                                 // Fresh read after refill
    FLUSH                                   // Invalidation walk over all sets
  } cache_state_e;

  typedef struct packed {
    logic              valid;               // One-cycle strobe
    logic [ADDR_W-1:0] addr;                // Byte address
  } cpu_req_t;

  typedef struct packed {
    logic              valid;               // One-cycle pulse
    logic [WORD_W-1:0] data;                // Requested word
  } cpu_resp_t;

endpackage

`default_nettype wire

// ==== source/a_defines.svh ====
`ifndef A_DEFINES_SVH
`define A_DEFINES_SVH

// Selects the behavioral RAM body in dpsram
`define _VERILATOR 1

// RAM contents cleared while reset is held
`define RAM_RST_CLEAR 1

`endif
